/* hw/serial_core_pkg.sv */
`default_nettype none

package serial_core_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_addr_t;
   typedef logic [4:0]  bit_cnt_t;
   typedef logic [2:0]  funct3_t;
   typedef logic [4:0]  opcode_t;

   // major opcodes, instr[6:2]
   localparam opcode_t OP_OPIMM = 5'b00100;
   localparam opcode_t OP_OP    = 5'b01100;
   localparam opcode_t OP_LUI   = 5'b01101;

   localparam funct3_t F3_ADD  = 3'b000; // add/sub
   localparam funct3_t F3_SLL  = 3'b001;
   localparam funct3_t F3_SLT  = 3'b010;
   localparam funct3_t F3_SLTU = 3'b011;
   localparam funct3_t F3_XOR  = 3'b100;
   localparam funct3_t F3_SR   = 3'b101; // srl/sra
   localparam funct3_t F3_OR   = 3'b110;
   localparam funct3_t F3_AND  = 3'b111;

   typedef enum logic [1:0] {
      IDLE,
      COMPARE,
      SH_INIT,
      RUN
   } decode_state_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SR,   // both shift directions
      ALU_LT,
      ALU_XOR,
      ALU_OR,
      ALU_AND
   } alu_sel_t;

   typedef enum logic {
      RD_SRC_ALU,
      RD_SRC_IMM
   } rd_src_t;

endpackage

`default_nettype wire

/* hw/serial_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module serial_decode
   import serial_core_pkg::*;
(
   input  wire        clk,
   input  wire        i_reset,
   input  wire word_t i_ibus_dat,
   input  wire        i_ibus_vld,
   output logic       o_ibus_rdy,
   output bit_cnt_t   o_cnt,
   output logic       o_rs_en,
   output reg_addr_t  o_rs1_addr,
   output reg_addr_t  o_rs2_addr,
   output logic       o_rd_en,
   output reg_addr_t  o_rd_addr,
   output logic       o_alu_en,
   output logic       o_alu_init,
   output logic       o_alu_sub,
   output alu_sel_t   o_alu_sel,
   output logic       o_alu_cmp_uns,
   output logic       o_alu_sh_right,
   output logic       o_alu_sh_signed,
   output logic       o_alu_shamt_en,
   output logic       o_op_b_imm,
   output logic       o_imm_bit,
   output rd_src_t    o_rd_src
);

   word_t         instr;
   decode_state_t state;
   bit_cnt_t      cnt;

   opcode_t opcode;
   funct3_t funct3;
   opcode_t new_opcode;
   funct3_t new_funct3;
   logic    go;
   logic    cnt_done;
   logic    supported;
   logic    new_alu;
   logic    new_slt;
   logic    new_shift;

   assign opcode     = instr[6:2];
   assign funct3     = instr[14:12];
   assign new_opcode = i_ibus_dat[6:2];   // first phase picked from the bus word
   assign new_funct3 = i_ibus_dat[14:12];

   assign go        = i_ibus_vld & o_ibus_rdy;
   assign cnt_done  = (cnt == 5'd31);
   assign supported = (opcode == OP_OPIMM) | (opcode == OP_OP) | (opcode == OP_LUI);

   // slt and shifts need an extra 32-cycle phase
   assign new_alu   = (new_opcode == OP_OPIMM) | (new_opcode == OP_OP);
   assign new_slt   = new_alu & (new_funct3[2:1] == 2'b01);
   assign new_shift = new_alu & (new_funct3[1:0] == 2'b01);

   //////////////////////////////////////////////////////////////////////
   // phase state machine and bit counter
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (i_reset) begin
         state      <= IDLE;
         cnt        <= '0;
         o_ibus_rdy <= 1'b1;
      end else begin
         case (state)
            IDLE: begin
               if (go) begin
                  if (new_slt)
                     state <= COMPARE;
                  else if (new_shift)
                     state <= SH_INIT;
                  else
                     state <= RUN;
               end
            end
            COMPARE, SH_INIT: begin
               if (cnt_done)
                  state <= RUN;
            end
            RUN: begin
               if (cnt_done)
                  state <= IDLE;
            end
            default: state <= IDLE;
         endcase

         if (state != IDLE)
            cnt <= cnt + 5'd1; // wraps into the next phase

         if (go)
            o_ibus_rdy <= 1'b0;
         else if ((state == RUN) & cnt_done)
            o_ibus_rdy <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (go)
         instr <= i_ibus_dat;
   end

   //////////////////////////////////////////////////////////////////////
   // per-bit control
   //////////////////////////////////////////////////////////////////////

   assign o_cnt      = cnt;
   assign o_rs_en    = (state != IDLE);
   assign o_alu_en   = (state != IDLE);
   assign o_alu_init = (state == COMPARE) | (state == SH_INIT);

   assign o_rs1_addr = instr[19:15];
   assign o_rs2_addr = instr[24:20];
   assign o_rd_addr  = instr[11:7];
   assign o_rd_en    = (state == RUN) & supported & (o_rd_addr != 5'd0);

   // sub for OP funct7 bit, and always for compares
   assign o_alu_sub = ((opcode == OP_OP) & (funct3 == F3_ADD) & instr[30]) |
                      (funct3[2:1] == 2'b01);

   assign o_alu_cmp_uns   = funct3[0];
   assign o_alu_sh_right  = funct3[2];
   assign o_alu_sh_signed = instr[30];
   assign o_alu_shamt_en  = (state == SH_INIT) & (cnt < 5'd5);
   assign o_op_b_imm      = (opcode == OP_OPIMM);
   assign o_rd_src        = (opcode == OP_LUI) ? RD_SRC_IMM : RD_SRC_ALU;

   always_comb begin
      case (funct3)
         F3_ADD:          o_alu_sel = ALU_ADD;
         F3_SLL, F3_SR:   o_alu_sel = ALU_SR;
         F3_SLT, F3_SLTU: o_alu_sel = ALU_LT;
         F3_XOR:          o_alu_sel = ALU_XOR;
         F3_OR:           o_alu_sel = ALU_OR;
         F3_AND:          o_alu_sel = ALU_AND;
         default:         o_alu_sel = ALU_ADD;
      endcase
   end

   // immediate bit at position cnt
   always_comb begin
      o_imm_bit = 1'b0;
      if (opcode == OP_OPIMM) begin
         if (cnt > 5'd10)
            o_imm_bit = instr[31]; // sign extension
         else
            o_imm_bit = instr[cnt + 5'd20];
      end else if (opcode == OP_LUI) begin
         if (cnt > 5'd11)
            o_imm_bit = instr[cnt];
      end
   end

endmodule

`default_nettype wire

/* hw/serial_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module serial_alu
   import serial_core_pkg::*;
(
   input  wire           clk,
   input  wire           i_reset,
   input  wire bit_cnt_t i_cnt,
   input  wire           i_en,
   input  wire           i_init,
   input  wire           i_sub,
   input  wire alu_sel_t i_sel,
   input  wire           i_cmp_uns,
   input  wire           i_sh_right,
   input  wire           i_sh_signed,
   input  wire           i_shamt_en,
   input  wire           i_op_b_imm,
   input  wire           i_rs1_bit,
   input  wire           i_rs2_bit,
   input  wire           i_imm_bit,
   output logic          o_rd_bit
);

   logic       b_bit;
   logic       b_inv;
   logic       carry;
   logic       carry_in;
   logic       sum_bit;
   logic       carry_out;
   logic       lt_flag;
   logic       lt_now;
   bit_cnt_t   shamt;
   word_t      sh_buf;
   logic [5:0] sh_r_idx;
   logic [5:0] sh_l_idx;
   logic       sh_bit;
   logic       result;

   assign b_bit = i_op_b_imm ? i_imm_bit : i_rs2_bit;
   assign b_inv = b_bit ^ i_sub;

   //////////////////////////////////////////////////////////////////////
   // adder, carry restarts at bit 0
   //////////////////////////////////////////////////////////////////////

   assign carry_in  = (i_cnt == 5'd0) ? i_sub : carry; // +1 for two's complement
   assign sum_bit   = i_rs1_bit ^ b_inv ^ carry_in;
   assign carry_out = (i_rs1_bit & b_inv) | (i_rs1_bit & carry_in) | (b_inv & carry_in);

   // valid at bit 31 of the compare phase
   assign lt_now = i_cmp_uns ? ~carry_out :
                   ((i_rs1_bit ^ b_bit) ? i_rs1_bit : sum_bit);

   always_ff @(posedge clk) begin
      if (i_reset) begin
         carry   <= 1'b0;
         lt_flag <= 1'b0;
         shamt   <= '0;
      end else if (i_en) begin
         carry <= carry_out;
         if (i_init & (i_sel == ALU_LT) & (i_cnt == 5'd31))
            lt_flag <= lt_now;
         if (i_shamt_en)
            shamt <= {b_bit, shamt[4:1]}; // lsb first
      end
   end

   //////////////////////////////////////////////////////////////////////
   // shifter
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (i_en & i_init)
         sh_buf <= {i_rs1_bit, sh_buf[31:1]}; // rs1 word after 32 bits
   end

   assign sh_r_idx = {1'b0, i_cnt} + {1'b0, shamt};
   assign sh_l_idx = {1'b0, i_cnt} - {1'b0, shamt};

   always_comb begin
      if (i_sh_right) begin
         if (sh_r_idx[5])
            sh_bit = i_sh_signed & sh_buf[31];
         else
            sh_bit = sh_buf[sh_r_idx[4:0]];
      end else begin
         if (sh_l_idx[5])
            sh_bit = 1'b0; // below shift amount
         else
            sh_bit = sh_buf[sh_l_idx[4:0]];
      end
   end

   always_comb begin
      case (i_sel)
         ALU_ADD: result = sum_bit;
         ALU_SR:  result = sh_bit;
         ALU_LT:  result = (i_cnt == 5'd0) & lt_flag;
         ALU_XOR: result = i_rs1_bit ^ b_bit;
         ALU_OR:  result = i_rs1_bit | b_bit;
         ALU_AND: result = i_rs1_bit & b_bit;
         default: result = 1'b0;
      endcase
   end

   assign o_rd_bit = i_en & result;

endmodule

`default_nettype wire

/* hw/serial_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module serial_regfile
   import serial_core_pkg::*;
(
   input  wire            clk,
   input  wire            i_reset,
   input  wire bit_cnt_t  i_cnt,
   input  wire            i_rs_en,
   input  wire reg_addr_t i_rs1_addr,
   input  wire reg_addr_t i_rs2_addr,
   input  wire            i_rd_en,
   input  wire reg_addr_t i_rd_addr,
   input  wire            i_rd_bit,
   input  wire reg_addr_t i_dbg_addr,
   output logic           o_rs1_bit,
   output logic           o_rs2_bit,
   output word_t          o_dbg_dat
);

   word_t regs [32];
   word_t rs1_word;
   word_t rs2_word;
   logic  wr_en;

   //////////////////////////////////////////////////////////////////////
   // bit-serial read ports
   //////////////////////////////////////////////////////////////////////

   assign rs1_word = regs[i_rs1_addr];
   assign rs2_word = regs[i_rs2_addr];

   // same bit as the write, so rd may equal a source
   assign o_rs1_bit = i_rs_en & rs1_word[i_cnt];
   assign o_rs2_bit = i_rs_en & rs2_word[i_cnt];

   assign o_dbg_dat = regs[i_dbg_addr]; // debug, whole word

   //////////////////////////////////////////////////////////////////////
   // bit-serial write port
   //////////////////////////////////////////////////////////////////////

   assign wr_en = i_rd_en & (i_rd_addr != 5'd0); // x0 stays zero

   always_ff @(posedge clk) begin
      if (i_reset) begin
         for (int i = 0; i < 32; i++)
            regs[i] <= '0;
      end else if (wr_en) begin
         regs[i_rd_addr][i_cnt] <= i_rd_bit;
      end
   end

endmodule

`default_nettype wire

/* hw/serial_core.sv */
`timescale 1ns/1ps
`default_nettype none

module serial_core
   import serial_core_pkg::*;
(
   input  wire            clk,
   input  wire            i_reset,
   input  wire word_t     i_ibus_dat,
   input  wire            i_ibus_vld,
   output logic           o_ibus_rdy,
   input  wire reg_addr_t i_dbg_addr,
   output word_t          o_dbg_dat
);

   bit_cnt_t  cnt;
   logic      rs_en;
   reg_addr_t rs1_addr;
   reg_addr_t rs2_addr;
   logic      rd_en;
   reg_addr_t rd_addr;
   logic      alu_en;
   logic      alu_init;
   logic      alu_sub;
   alu_sel_t  alu_sel;
   logic      alu_cmp_uns;
   logic      alu_sh_right;
   logic      alu_sh_signed;
   logic      alu_shamt_en;
   logic      op_b_imm;
   logic      imm_bit;
   rd_src_t   rd_src;
   logic      rs1_bit;
   logic      rs2_bit;
   logic      alu_rd_bit;
   logic      rd_bit;

   serial_decode decode (
      .clk             (clk),
      .i_reset         (i_reset),
      .i_ibus_dat      (i_ibus_dat),
      .i_ibus_vld      (i_ibus_vld),
      .o_ibus_rdy      (o_ibus_rdy),
      .o_cnt           (cnt),
      .o_rs_en         (rs_en),
      .o_rs1_addr      (rs1_addr),
      .o_rs2_addr      (rs2_addr),
      .o_rd_en         (rd_en),
      .o_rd_addr       (rd_addr),
      .o_alu_en        (alu_en),
      .o_alu_init      (alu_init),
      .o_alu_sub       (alu_sub),
      .o_alu_sel       (alu_sel),
      .o_alu_cmp_uns   (alu_cmp_uns),
      .o_alu_sh_right  (alu_sh_right),
      .o_alu_sh_signed (alu_sh_signed),
      .o_alu_shamt_en  (alu_shamt_en),
      .o_op_b_imm      (op_b_imm),
      .o_imm_bit       (imm_bit),
      .o_rd_src        (rd_src)
   );

   serial_alu alu (
      .clk         (clk),
      .i_reset     (i_reset),
      .i_cnt       (cnt),
      .i_en        (alu_en),
      .i_init      (alu_init),
      .i_sub       (alu_sub),
      .i_sel       (alu_sel),
      .i_cmp_uns   (alu_cmp_uns),
      .i_sh_right  (alu_sh_right),
      .i_sh_signed (alu_sh_signed),
      .i_shamt_en  (alu_shamt_en),
      .i_op_b_imm  (op_b_imm),
      .i_rs1_bit   (rs1_bit),
      .i_rs2_bit   (rs2_bit),
      .i_imm_bit   (imm_bit),
      .o_rd_bit    (alu_rd_bit)
   );

   // write-back source, lui takes the immediate directly
   assign rd_bit = (rd_src == RD_SRC_IMM) ? imm_bit : alu_rd_bit;

   serial_regfile regfile (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_cnt      (cnt),
      .i_rs_en    (rs_en),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd_en    (rd_en),
      .i_rd_addr  (rd_addr),
      .i_rd_bit   (rd_bit),
      .i_dbg_addr (i_dbg_addr),
      .o_rs1_bit  (rs1_bit),
      .o_rs2_bit  (rs2_bit),
      .o_dbg_dat  (o_dbg_dat)
   );

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
   output logic clk,
   output logic o_reset
);

   localparam int HALF_PERIOD  = 20; // 40 ns period
   localparam int RESET_CYCLES = 3;

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   initial begin
      o_reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      o_reset <= 1'b0;
   end

endmodule

`default_nettype wire

/* tb/serial_core_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module serial_core_checker
   import serial_core_pkg::*;
(
   input  wire            clk,
   input  wire            i_reset,
   input  wire word_t     i_ibus_dat,
   input  wire            i_ibus_vld,
   input  wire            i_ibus_rdy,
   input  wire reg_addr_t i_dbg_addr,
   input  wire word_t     i_dbg_dat,
   output int             o_errors,
   output int             o_accepted
);

   word_t     model [32];
   reg_addr_t last_addr;
   logic      after_reset;
   string     test_name;

   //////////////////////////////////////////////////////////////////////
   // reference model
   //////////////////////////////////////////////////////////////////////

   function automatic logic is_supported(input opcode_t op);
      return (op == OP_OPIMM) || (op == OP_OP) || (op == OP_LUI);
   endfunction

   // rv32i result written to rd
   function automatic word_t expected_rd(input word_t w, input word_t a, input word_t rs2_val);
      opcode_t op;
      funct3_t f3;
      word_t   b;
      op = w[6:2];
      f3 = w[14:12];
      b  = (op == OP_OPIMM) ? {{20{w[31]}}, w[31:20]} : rs2_val; // sign-extended imm
      if (op == OP_LUI)
         return {w[31:12], 12'h000};
      case (f3)
         F3_ADD:  return (op == OP_OP && w[30]) ? a - b : a + b;
         F3_SLL:  return a << b[4:0];
         F3_SLT:  return {31'd0, $signed(a) < $signed(b)};
         F3_SLTU: return {31'd0, a < b};
         F3_XOR:  return a ^ b;
         F3_SR: begin
            if (w[30])
               return $signed(a) >>> b[4:0];
            else
               return a >> b[4:0];
         end
         F3_OR:   return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic string instr_name(input word_t w);
      string base;
      case (w[14:12])
         F3_ADD:  base = (w[6:2] == OP_OP && w[30]) ? "sub" : "add";
         F3_SLL:  base = "sll";
         F3_SLT:  base = "slt";
         F3_SLTU: base = "sltu";
         F3_XOR:  base = "xor";
         F3_SR:   base = w[30] ? "sra" : "srl";
         F3_OR:   base = "or";
         default: base = "and";
      endcase
      if (w[6:2] == OP_LUI)
         return "lui";
      else if (w[6:2] == OP_OP)
         return base;
      else if (w[6:2] != OP_OPIMM)
         return "unsupported";
      else if (base == "sltu")
         return "sltiu";
      else
         return {base, "i"};
   endfunction

   //////////////////////////////////////////////////////////////////////
   // monitor
   //////////////////////////////////////////////////////////////////////

   initial begin
      o_errors    = 0;
      o_accepted  = 0;
      after_reset = 1'b0;
   end

   always @(posedge clk) begin
      if (i_reset) begin
         for (int i = 0; i < 32; i++)
            model[i] = '0;
         last_addr   = i_dbg_addr;
         after_reset = 1'b1;
         test_name   = "reset";
      end else begin
         if (after_reset && !i_ibus_rdy) begin
            o_errors++;
            $display("ready is low on the first cycle after reset");
         end
         after_reset = 1'b0;

         // new address, debug read has no latency
         if (i_dbg_addr != last_addr && i_dbg_dat !== model[i_dbg_addr]) begin
            o_errors++;
            $display("CHECK FAILED %s: x%0d expected %08h actual %08h",
                     test_name, i_dbg_addr, model[i_dbg_addr], i_dbg_dat);
         end
         last_addr = i_dbg_addr;

         if (i_ibus_vld && i_ibus_rdy) begin
            o_accepted++;
            test_name = $sformatf("%s #%0d", instr_name(i_ibus_dat), o_accepted);
            if (is_supported(i_ibus_dat[6:2]) && i_ibus_dat[11:7] != 5'd0)
               model[i_ibus_dat[11:7]] = expected_rd(i_ibus_dat,
                                                     model[i_ibus_dat[19:15]],
                                                     model[i_ibus_dat[24:20]]);
         end
      end
   end

endmodule

`default_nettype wire

/* tb/serial_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module serial_core_tb
   import serial_core_pkg::*;
();

   logic      clk;
   logic      reset;
   word_t     ibus_dat;
   logic      ibus_vld;
   logic      ibus_rdy;
   reg_addr_t dbg_addr;
   word_t     dbg_dat;
   int        chk_errors;
   int        chk_accepted;
   int        tb_errors = 0;
   int        issued    = 0;
   int        cycle_cnt = 0;
   integer    seed;

   tb_clock_gen clock_gen (
      .clk     (clk),
      .o_reset (reset)
   );

   serial_core uut (
      .clk        (clk),
      .i_reset    (reset),
      .i_ibus_dat (ibus_dat),
      .i_ibus_vld (ibus_vld),
      .o_ibus_rdy (ibus_rdy),
      .i_dbg_addr (dbg_addr),
      .o_dbg_dat  (dbg_dat)
   );

   serial_core_checker chk (
      .clk        (clk),
      .i_reset    (reset),
      .i_ibus_dat (ibus_dat),
      .i_ibus_vld (ibus_vld),
      .i_ibus_rdy (ibus_rdy),
      .i_dbg_addr (dbg_addr),
      .i_dbg_dat  (dbg_dat),
      .o_errors   (chk_errors),
      .o_accepted (chk_accepted)
   );

   //////////////////////////////////////////////////////////////////////
   // instruction encoding
   //////////////////////////////////////////////////////////////////////

   function automatic word_t encode_r(input funct3_t f3, input reg_addr_t rd,
                                      input reg_addr_t rs1, input reg_addr_t rs2,
                                      input logic [6:0] f7);
      return {f7, rs2, rs1, f3, rd, OP_OP, 2'b11};
   endfunction

   function automatic word_t encode_i(input funct3_t f3, input reg_addr_t rd,
                                      input reg_addr_t rs1, input logic [11:0] imm);
      return {imm, rs1, f3, rd, OP_OPIMM, 2'b11};
   endfunction

   function automatic word_t encode_u(input reg_addr_t rd, input logic [19:0] imm);
      return {imm, rd, OP_LUI, 2'b11};
   endfunction

   function automatic reg_addr_t pick_reg();
      int r;
      r = 1 + ({$random(seed)} % 12);
      return r[4:0];
   endfunction

   //////////////////////////////////////////////////////////////////////
   // stimulus tasks
   //////////////////////////////////////////////////////////////////////

   // valid held a few cycles past acceptance, then rd shown on debug port
   task automatic run_instr(input word_t instr);
      int hold;
      hold = {$random(seed)} % 4;
      @(posedge clk);
      ibus_dat <= instr;
      ibus_vld <= 1'b1;
      issued++;
      do begin
         @(posedge clk);
      end while (!ibus_rdy);
      repeat (hold) @(posedge clk);
      ibus_vld <= 1'b0;
      dbg_addr <= instr[11:7] ^ 5'd1; // some other register while busy
      do begin
         @(posedge clk);
      end while (!ibus_rdy);
      dbg_addr <= instr[11:7];
      repeat (2) @(posedge clk);
   endtask

   task automatic sweep_debug_port();
      int a;
      for (a = 1; a <= 32; a++) begin
         @(posedge clk);
         dbg_addr <= a[4:0];
      end
      repeat (3) @(posedge clk);
   endtask

   task automatic load_immediates();
      word_t rnd;
      int    r;
      for (r = 1; r <= 10; r++) begin
         rnd = $random(seed);
         run_instr(encode_u(r[4:0], rnd[31:12]));
         run_instr(encode_i(F3_ADD, r[4:0], r[4:0], rnd[11:0]));
      end
      rnd = $random(seed);
      run_instr(encode_i(F3_ADD, 5'd11, 5'd0, {1'b1, rnd[10:0]})); // negative
      run_instr(encode_i(F3_ADD, 5'd12, 5'd0, rnd[11:0]));
   endtask

   task automatic random_alu_ops();
      word_t     rnd;
      reg_addr_t rs1;
      reg_addr_t rs2;
      reg_addr_t rd;
      int        k;
      for (k = 0; k < 30; k++) begin
         rnd = $random(seed);
         rs1 = pick_reg();
         rs2 = pick_reg();
         rd  = (k % 3 == 0) ? rs1 : pick_reg();
         case ({$random(seed)} % 9)
            0: run_instr(encode_r(F3_ADD, rd, rs1, rs2, 7'h00));
            1: run_instr(encode_r(F3_ADD, rd, rs1, rs2, 7'h20));
            2: run_instr(encode_r(F3_XOR, rd, rs1, rs2, 7'h00));
            3: run_instr(encode_r(F3_OR, rd, rs1, rs2, 7'h00));
            4: run_instr(encode_r(F3_AND, rd, rs1, rs2, 7'h00));
            5: run_instr(encode_i(F3_ADD, rd, rs1, rnd[11:0]));
            6: run_instr(encode_i(F3_XOR, rd, rs1, rnd[11:0]));
            7: run_instr(encode_i(F3_OR, rd, rs1, rnd[11:0]));
            default: run_instr(encode_i(F3_AND, rd, rs1, rnd[11:0]));
         endcase
      end
   endtask

   task automatic compare_ops();
      word_t   rnd;
      funct3_t f3;
      int      k;
      run_instr(encode_u(5'd20, 20'h80000));
      run_instr(encode_u(5'd21, 20'h80000));
      run_instr(encode_i(F3_ADD, 5'd21, 5'd21, 12'hfff)); // 0x7fffffff
      run_instr(encode_i(F3_ADD, 5'd22, 5'd21, 12'h000));
      run_instr(encode_r(F3_SLT, 5'd26, 5'd20, 5'd21, 7'h00));
      run_instr(encode_r(F3_SLTU, 5'd27, 5'd20, 5'd21, 7'h00));
      run_instr(encode_r(F3_SLT, 5'd26, 5'd21, 5'd20, 7'h00));
      run_instr(encode_r(F3_SLTU, 5'd27, 5'd21, 5'd20, 7'h00));
      run_instr(encode_r(F3_SLT, 5'd26, 5'd21, 5'd22, 7'h00)); // equal
      run_instr(encode_r(F3_SLTU, 5'd27, 5'd0, 5'd20, 7'h00));
      run_instr(encode_i(F3_SLT, 5'd26, 5'd20, 12'hfff));
      run_instr(encode_i(F3_SLTU, 5'd27, 5'd0, 12'hfff));
      run_instr(encode_i(F3_SLTU, 5'd26, 5'd21, 12'h7ff));
      run_instr(encode_i(F3_SLT, 5'd27, 5'd21, 12'h800));
      for (k = 0; k < 8; k++) begin
         rnd = $random(seed);
         f3  = rnd[0] ? F3_SLTU : F3_SLT;
         if (rnd[1])
            run_instr(encode_i(f3, pick_reg(), pick_reg(), rnd[31:20]));
         else
            run_instr(encode_r(f3, pick_reg(), pick_reg(), pick_reg(), 7'h00));
      end
   endtask

   task automatic shift_ops();
      word_t     rnd;
      reg_addr_t src;
      reg_addr_t amt_reg;
      logic [4:0] sh;
      int        k;
      int        j;
      rnd = $random(seed);
      run_instr(encode_i(F3_ADD, 5'd23, 5'd0, 12'd31));
      run_instr(encode_i(F3_ADD, 5'd25, 5'd0, rnd[11:0])); // upper bits ignored
      for (k = 0; k < 2; k++) begin
         rnd = $random(seed);
         src = (k == 0) ? 5'd20 : pick_reg();
         for (j = 0; j < 3; j++) begin
            amt_reg = (j == 0) ? 5'd0 : (j == 1) ? 5'd23 : 5'd25;
            sh      = (j == 0) ? 5'd0 : (j == 1) ? 5'd31 : rnd[4:0];
            run_instr(encode_r(F3_SLL, 5'd28, src, amt_reg, 7'h00));
            run_instr(encode_r(F3_SR, 5'd29, src, amt_reg, 7'h00));
            run_instr(encode_r(F3_SR, 5'd28, src, amt_reg, 7'h20));
            run_instr(encode_i(F3_SLL, 5'd29, src, {7'h00, sh}));
            run_instr(encode_i(F3_SR, 5'd28, src, {7'h00, sh}));
            run_instr(encode_i(F3_SR, src, src, {7'h20, sh})); // in place
         end
      end
   endtask

   task automatic x0_and_unsupported();
      word_t rnd;
      rnd = $random(seed);
      run_instr(encode_i(F3_ADD, 5'd0, 5'd1, rnd[11:0]));
      run_instr(encode_u(5'd0, rnd[31:12]));
      run_instr(encode_r(F3_OR, 5'd0, 5'd1, 5'd2, 7'h00));
      run_instr({rnd[31:12], 5'd5, 7'b0000011}); // load
      run_instr({rnd[31:12], 5'd6, 7'b1101111}); // jal
      run_instr({rnd[31:7], 7'b1100011});        // branch
   endtask

   //////////////////////////////////////////////////////////////////////
   // main sequence and timeout
   //////////////////////////////////////////////////////////////////////

   initial begin
      seed     = 32'h90f9;
      ibus_dat = '0;
      ibus_vld = 1'b0;
      dbg_addr = '0;
      wait (reset === 1'b0);
      sweep_debug_port(); // all zero after reset
      load_immediates();
      random_alu_ops();
      compare_ops();
      shift_ops();
      x0_and_unsupported();
      sweep_debug_port();
      repeat (3) @(posedge clk);
      if (chk_accepted != issued) begin
         tb_errors++;
         $display("%0d words were accepted but %0d were issued", chk_accepted, issued);
      end
      $display("closing: %0d check errors, %0d testbench errors, %0d instructions issued",
               chk_errors, tb_errors, issued);
      if (chk_errors == 0 && tb_errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

   // 64-cycle instructions plus handshake slack
   initial begin
      while (cycle_cnt <= 70 * issued + 200) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("timeout after %0d cycles with %0d instructions issued", cycle_cnt, issued);
      $display("Something failed");
      $finish;
   end

endmodule

`default_nettype wire

/* serial_core.f */
hw/serial_core_pkg.sv
hw/serial_decode.sv
hw/serial_alu.sv
hw/serial_regfile.sv
hw/serial_core.sv
tb/tb_clock_gen.sv
tb/serial_core_checker.sv
tb/serial_core_tb.sv
